// File: bench/core_tb.sv
`default_nettype none

module core_tb
   import core_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] seed = 32'h6e71_e179;

   typedef struct packed {
      word_t              addr;
      word_t              data;
      logic [wsize_w-1:0] size;
   } store_rec_t;

   logic               clk;
   logic               arst_n;
   logic               instr_valid;
   instr_t             instr;
   logic               instr_ready;
   logic               wmem_valid;
   logic               wmem_ready;
   word_t              wmem_address;
   word_t              wmem_wr_data;
   logic [wsize_w-1:0] wmem_wr_size;

   logic [31:0] lfsr_q;
   logic [31:0] ready_lfsr_q;
   logic        stall_mode;
   logic        store_issued;
   logic        xfer_pending;
   word_t       model [reg_count];
   store_rec_t  exp_q [$];
   store_rec_t  head;
   logic        head_valid;
   string       test_name;
   int          issued;
   int          cycles;
   int          errors;
   int          checked;
   int          tests_run;
   int          tests_failed;
   int          errors_at_start;
   int          checked_at_start;

   core_top core_top_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_ready (instr_ready),
      .wmem_valid  (wmem_valid),
      .wmem_ready  (wmem_ready),
      .wmem_address(wmem_address),
      .wmem_wr_data(wmem_wr_data),
      .wmem_wr_size(wmem_wr_size)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] draw(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic reg_idx_t rand_reg();
      logic [31:0] v;
      v = draw(3);
      return v[2:0];
   endfunction

   function automatic logic [15:0] rand_imm();
      logic [31:0] v;
      v = draw(16);
      return v[15:0];
   endfunction

   function automatic op_e rand_alu_op();
      logic [31:0] v;
      op_e         op;
      v = draw(3);
      case (v[2:0])
         3'd0:    op = op_add;
         3'd1:    op = op_sub;
         3'd2:    op = op_and;
         3'd3:    op = op_or;
         3'd4:    op = op_xor;
         3'd5:    op = op_movi;
         default: op = op_addi;
      endcase
      return op;
   endfunction

   function automatic instr_t make_instr(input op_e op, input reg_idx_t dst,
                                         input reg_idx_t src, input size_e size,
                                         input logic [15:0] imm);
      instr_t w;
      w.op   = op;
      w.dst  = dst;
      w.src  = src;
      w.size = size;
      w.rsvd = 4'h0;
      w.imm  = imm;
      return w;
   endfunction

   task automatic refresh_head();
      head_valid = exp_q.size() != 0;
      if (head_valid) begin
         head = exp_q[0];
      end
   endtask

   // sequential reference, one accepted instruction at a time
   task automatic model_commit(input instr_t w);
      word_t      imm;
      word_t      tmp;
      store_rec_t rec;
      imm = {16'h0000, w.imm};
      case (w.op)
         op_add:  model[w.dst] = model[w.dst] + model[w.src];
         op_sub:  model[w.dst] = model[w.dst] - model[w.src];
         op_and:  model[w.dst] = model[w.dst] & model[w.src];
         op_or:   model[w.dst] = model[w.dst] | model[w.src];
         op_xor:  model[w.dst] = model[w.dst] ^ model[w.src];
         op_movi: model[w.dst] = imm;
         op_addi: model[w.dst] = model[w.dst] + imm;
         op_xchg: begin
            tmp          = model[w.dst];
            model[w.dst] = model[w.src];
            model[w.src] = tmp;
         end
         op_store: begin
            rec.addr = model[w.src] + imm;
            case (w.size)
               sz_byte: begin
                  rec.size = 2'd0;
                  rec.data = model[w.dst] & 32'h0000_00ff;
               end
               sz_half: begin
                  rec.size = 2'd1;
                  rec.data = model[w.dst] & 32'h0000_ffff;
               end
               default: begin
                  rec.size = 2'd2;
                  rec.data = model[w.dst];
               end
            endcase
            exp_q.push_back(rec);
            store_issued = 1'b1;
            refresh_head();
         end
         default: begin
         end
      endcase
   endtask

   // present one instruction and hold it until the core takes it
   task automatic issue(input instr_t w);
      logic taken;
      instr_valid = 1'b1;
      instr       = w;
      issued++;
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = instr_ready;
         @(posedge clk);
      end
      model_commit(w);
      #0.5;
      instr_valid = 1'b0;
   endtask

   // every register to memory, base r0, one word apart
   task automatic dump_regs();
      for (int i = 0; i < reg_count; i++) begin
         issue(make_instr(op_store, 3'(i), 3'd0, sz_word, 16'(i * 4)));
      end
   endtask

   task automatic start_test(input string name);
      test_name        = name;
      errors_at_start  = errors;
      checked_at_start = checked;
   endtask

   task automatic end_test();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      @(posedge clk);
      #0.5;
      tests_run++;
      if (errors != errors_at_start) begin
         tests_failed++;
      end
      $display("test %-12s stores checked %0d, errors %0d", test_name,
               checked - checked_at_start, errors - errors_at_start);
   endtask

   task automatic reset_test();
      start_test("reset");
      // falling edge after time zero so the async reset is seen
      #1;
      arst_n = 1'b0;
      repeat (16) @(posedge clk);
      #0.5;
      arst_n = 1'b1;
      @(negedge clk);
      a_ready_after_reset: assert (instr_ready) else begin
         $display("instr_ready is low in the first cycle after reset");
         errors++;
      end
      @(posedge clk);
      #0.5;
      // nop and an unused opcode pass the result stage with no memory write
      issue(make_instr(op_nop, 3'd1, 3'd2, sz_word, 16'hffff));
      issue(make_instr(op_e'(4'hf), 3'd3, 3'd4, sz_word, 16'h1234));
      repeat (3) @(posedge clk);
      #0.5;
      dump_regs();
      end_test();
   endtask

   task automatic alu_random_test();
      op_e         op;
      reg_idx_t    d;
      reg_idx_t    s;
      logic [15:0] imm;
      start_test("alu_random");
      repeat (3) begin
         repeat (10) begin
            op  = rand_alu_op();
            d   = rand_reg();
            s   = rand_reg();
            imm = rand_imm();
            issue(make_instr(op, d, s, sz_word, imm));
         end
         dump_regs();
      end
      end_test();
   endtask

   // each instruction reads the register written just before it
   task automatic dependency_test();
      op_e      op;
      reg_idx_t prev;
      reg_idx_t d;
      start_test("dependency");
      prev = rand_reg();
      issue(make_instr(op_movi, prev, prev, sz_word, rand_imm()));
      repeat (16) begin
         op = rand_alu_op();
         d  = rand_reg();
         if (op == op_movi) begin
            op = op_sub;
         end
         // addi only reads its destination
         if (op == op_addi) begin
            d = prev;
         end
         issue(make_instr(op, d, prev, sz_word, rand_imm()));
         prev = d;
      end
      dump_regs();
      end_test();
   endtask

   task automatic exchange_test();
      reg_idx_t d;
      reg_idx_t s;
      start_test("exchange");
      for (int i = 0; i < reg_count; i++) begin
         issue(make_instr(op_movi, 3'(i), 3'd0, sz_word, rand_imm()));
      end
      issue(make_instr(op_xchg, 3'd2, 3'd5, sz_word, 16'h0000));
      issue(make_instr(op_xchg, 3'd3, 3'd3, sz_word, 16'h0000));
      repeat (10) begin
         d = rand_reg();
         s = rand_reg();
         issue(make_instr(op_xchg, d, s, sz_word, 16'h0000));
      end
      dump_regs();
      end_test();
   endtask

   task automatic store_size_test();
      reg_idx_t d;
      reg_idx_t s;
      start_test("store_size");
      for (int i = 1; i < reg_count; i++) begin
         issue(make_instr(op_movi, 3'(i), 3'd0, sz_word, rand_imm()));
      end
      // differences often set the upper half too
      for (int i = 4; i < reg_count; i++) begin
         issue(make_instr(op_sub, 3'(i), 3'(i - 4), sz_word, 16'h0000));
      end
      for (int sz = 0; sz < 4; sz++) begin
         repeat (4) begin
            d = rand_reg();
            s = rand_reg();
            issue(make_instr(op_store, d, s, size_e'(2'(sz)), rand_imm()));
         end
      end
      end_test();
   endtask

   task automatic backpressure_test();
      logic [31:0] kind;
      logic [31:0] sz;
      op_e         op;
      reg_idx_t    d;
      reg_idx_t    s;
      start_test("backpressure");
      stall_mode = 1'b1;
      repeat (48) begin
         kind = draw(2);
         d    = rand_reg();
         s    = rand_reg();
         case (kind[1:0])
            2'd2:    op = op_xchg;
            2'd3:    op = op_store;
            default: op = rand_alu_op();
         endcase
         sz = draw(2);
         issue(make_instr(op, d, s, size_e'(sz[1:0]), rand_imm()));
      end
      dump_regs();
      end_test();
      stall_mode = 1'b0;
   endtask

   // memory side ready, random only while stall_mode is set
   initial begin
      wmem_ready   = 1'b1;
      ready_lfsr_q = seed;
      forever begin
         @(posedge clk);
         #0.5;
         if (stall_mode) begin
            ready_lfsr_q = lfsr_step(ready_lfsr_q);
            wmem_ready   = ready_lfsr_q[0];
         end else begin
            wmem_ready = 1'b1;
         end
      end
   end

   // inputs are stable at the falling edge, the queue head retires half a cycle after the transfer
   always @(negedge clk) begin
      if (xfer_pending && exp_q.size() != 0) begin
         void'(exp_q.pop_front());
         checked++;
         refresh_head();
      end
      xfer_pending = arst_n && wmem_valid && wmem_ready;
   end

   a_quiet_until_store: assert property (
      @(posedge clk) !store_issued |-> !wmem_valid
   ) else begin
      $display("wmem_valid went high before any store was issued");
      errors++;
   end

   a_xfer_expected: assert property (
      @(posedge clk) disable iff (!arst_n)
      wmem_valid && wmem_ready |-> head_valid
   ) else begin
      $display("memory write arrived with no store outstanding in test %s", test_name);
      errors++;
   end

   a_xfer_address: assert property (
      @(posedge clk) disable iff (!arst_n)
      wmem_valid && wmem_ready && head_valid |-> wmem_address == head.addr
   ) else begin
      $display("MISMATCH %s address expected %h actual %h",
               test_name, head.addr, $sampled(wmem_address));
      errors++;
   end

   a_xfer_data: assert property (
      @(posedge clk) disable iff (!arst_n)
      wmem_valid && wmem_ready && head_valid |-> wmem_wr_data == head.data
   ) else begin
      $display("MISMATCH %s data expected %h actual %h",
               test_name, head.data, $sampled(wmem_wr_data));
      errors++;
   end

   a_xfer_size: assert property (
      @(posedge clk) disable iff (!arst_n)
      wmem_valid && wmem_ready && head_valid |-> wmem_wr_size == head.size
   ) else begin
      $display("MISMATCH %s size expected %0d actual %0d",
               test_name, head.size, $sampled(wmem_wr_size));
      errors++;
   end

   a_request_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      wmem_valid && !wmem_ready |=> wmem_valid && $stable(wmem_address)
         && $stable(wmem_wr_data) && $stable(wmem_wr_size)
   ) else begin
      $display("memory write request changed while waiting in test %s", test_name);
      errors++;
   end

   // limit grows with the number of instructions issued
   initial begin
      cycles = 0;
      while (cycles <= 40 * issued + 200) begin
         @(posedge clk);
         cycles++;
      end
      $display("run stopped by timeout after %0d cycles, %0d instructions issued",
               cycles, issued);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      arst_n       = 1'b1;
      instr_valid  = 1'b0;
      instr        = '0;
      lfsr_q       = seed;
      stall_mode   = 1'b0;
      store_issued = 1'b0;
      xfer_pending = 1'b0;
      head         = '0;
      head_valid   = 1'b0;
      issued       = 0;
      errors       = 0;
      checked      = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < reg_count; i++) begin
         model[i] = '0;
      end
      reset_test();
      alu_random_test();
      dependency_test();
      exchange_test();
      store_size_test();
      backpressure_test();
      $display("tests %0d, failed %0d, stores checked %0d, errors %0d",
               tests_run, tests_failed, checked, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module core_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vcore_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$log"; then
   exit 1
fi

exit 0

// File: sim.f
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/pipe_reg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/core_top.sv
bench/core_tb.sv

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

   localparam int data_w    = 32;
   localparam int addr_w    = 32;
   localparam int reg_count = 8;
   localparam int reg_idx_w = 3;
   localparam int wsize_w   = 2;

   typedef logic [reg_idx_w-1:0] reg_idx_t;
   typedef logic [data_w-1:0]    word_t;

   // codes not listed here behave as nop
   typedef enum logic [3:0] {
      op_nop   = 4'd0,
      op_add   = 4'd1,
      op_sub   = 4'd2,
      op_and   = 4'd3,
      op_or    = 4'd4,
      op_xor   = 4'd5,
      op_movi  = 4'd6,
      op_addi  = 4'd7,
      op_store = 4'd8,
      op_xchg  = 4'd14
   } op_e;

   // size code 3 is handled as a word
   typedef enum logic [1:0] {
      sz_byte = 2'd0,
      sz_half = 2'd1,
      sz_word = 2'd2
   } size_e;

   // instruction word, op in 31:28 down to imm in 15:0
   typedef struct packed {
      op_e         op;
      reg_idx_t    dst;
      reg_idx_t    src;
      size_e       size;
      logic [3:0]  rsvd;
      logic [15:0] imm;
   } instr_t;

   // decode to execute
   typedef struct packed {
      op_e      op;
      reg_idx_t dst;
      reg_idx_t src;
      size_e    size;
      word_t    dst_val;
      word_t    src_val;
      word_t    imm;
   } dec_payload_t;

   // execute to result
   typedef struct packed {
      op_e               op;
      reg_idx_t          dst;
      reg_idx_t          src;
      size_e             size;
      word_t             lo;
      word_t             hi;
      logic [addr_w-1:0] addr;
   } exe_payload_t;

endpackage

`default_nettype wire

// File: verilog/core_top.sv
`default_nettype none

module core_top
   import core_pkg::*;
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               instr_valid,
   input  instr_t             instr,
   output logic               instr_ready,
   output logic               wmem_valid,
   input  logic               wmem_ready,
   output word_t              wmem_address,
   output word_t              wmem_wr_data,
   output logic [wsize_w-1:0] wmem_wr_size
);

   reg_idx_t     rd0_idx;
   reg_idx_t     rd1_idx;
   word_t        rd0_data;
   word_t        rd1_data;

   // write ports double as scoreboard retire strobes
   logic         wr0_en;
   logic         wr1_en;
   reg_idx_t     wr0_idx;
   reg_idx_t     wr1_idx;
   word_t        wr0_data;
   word_t        wr1_data;

   logic         d_valid;
   logic         d_ready;
   dec_payload_t d_data;
   logic         e_valid;
   logic         e_ready;
   exe_payload_t e_data;

   decode_stage decode_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .instr_valid(instr_valid),
      .instr      (instr),
      .instr_ready(instr_ready),
      .rd0_idx    (rd0_idx),
      .rd1_idx    (rd1_idx),
      .rd0_data   (rd0_data),
      .rd1_data   (rd1_data),
      .retire0    (wr0_en),
      .retire1    (wr1_en),
      .retire0_idx(wr0_idx),
      .retire1_idx(wr1_idx),
      .d_valid    (d_valid),
      .d_ready    (d_ready),
      .d_data     (d_data)
   );

   execute_stage execute_i (
      .clk    (clk),
      .arst_n (arst_n),
      .d_valid(d_valid),
      .d_ready(d_ready),
      .d_data (d_data),
      .e_valid(e_valid),
      .e_ready(e_ready),
      .e_data (e_data)
   );

   result_stage result_i (
      .e_valid     (e_valid),
      .e_ready     (e_ready),
      .e_data      (e_data),
      .wr0_en      (wr0_en),
      .wr1_en      (wr1_en),
      .wr0_idx     (wr0_idx),
      .wr1_idx     (wr1_idx),
      .wr0_data    (wr0_data),
      .wr1_data    (wr1_data),
      .wmem_valid  (wmem_valid),
      .wmem_ready  (wmem_ready),
      .wmem_address(wmem_address),
      .wmem_wr_data(wmem_wr_data),
      .wmem_wr_size(wmem_wr_size)
   );

   reg_file reg_file_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .rd0_idx (rd0_idx),
      .rd1_idx (rd1_idx),
      .rd0_data(rd0_data),
      .rd1_data(rd1_data),
      .wr0_en  (wr0_en),
      .wr1_en  (wr1_en),
      .wr0_idx (wr0_idx),
      .wr1_idx (wr1_idx),
      .wr0_data(wr0_data),
      .wr1_data(wr1_data)
   );

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage
   import core_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         instr_valid,
   input  instr_t       instr,
   output logic         instr_ready,
   output reg_idx_t     rd0_idx,
   output reg_idx_t     rd1_idx,
   input  word_t        rd0_data,
   input  word_t        rd1_data,
   input  logic         retire0,
   input  logic         retire1,
   input  reg_idx_t     retire0_idx,
   input  reg_idx_t     retire1_idx,
   output logic         d_valid,
   input  logic         d_ready,
   output dec_payload_t d_data
);

   logic [reg_count-1:0] busy_q;
   logic [reg_count-1:0] live_busy;
   logic [reg_count-1:0] name_mask;
   logic [reg_count-1:0] set_mask;
   logic [reg_count-1:0] retire_mask;
   logic                 hazard;
   logic                 pipe_ready;
   logic                 accept;
   logic                 dst_free;
   logic                 src_free;
   dec_payload_t         payload;

   function automatic logic [reg_count-1:0] onehot(input reg_idx_t idx);
      logic [reg_count-1:0] mask;
      mask      = '0;
      mask[idx] = 1'b1;
      return mask;
   endfunction

   // registers read and registers written, per opcode
   always_comb begin
      name_mask = '0;
      set_mask  = '0;
      case (instr.op)
         op_add, op_sub, op_and, op_or, op_xor: begin
            name_mask = onehot(instr.dst) | onehot(instr.src);
            set_mask  = onehot(instr.dst);
         end
         op_movi, op_addi: begin
            name_mask = onehot(instr.dst);
            set_mask  = onehot(instr.dst);
         end
         op_store: begin
            name_mask = onehot(instr.dst) | onehot(instr.src);
         end
         op_xchg: begin
            name_mask = onehot(instr.dst) | onehot(instr.src);
            set_mask  = name_mask;
         end
         default: begin
         end
      endcase
   end

   // a retiring register is free now, the regfile forwards its value
   assign retire_mask = (retire0 ? onehot(retire0_idx) : '0)
                      | (retire1 ? onehot(retire1_idx) : '0);
   assign live_busy   = busy_q & ~retire_mask;
   assign hazard      = instr_valid && |(name_mask & live_busy);
   assign instr_ready = pipe_ready && !hazard;
   assign accept      = instr_valid && instr_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q <= '0;
      end else begin
         busy_q <= live_busy | (accept ? set_mask : '0);
      end
   end

   assign rd0_idx = instr.dst;
   assign rd1_idx = instr.src;

   always_comb begin
      payload.op      = instr.op;
      payload.dst     = instr.dst;
      payload.src     = instr.src;
      payload.size    = instr.size;
      payload.dst_val = rd0_data;
      payload.src_val = rd1_data;
      payload.imm     = {{(data_w-16){1'b0}}, instr.imm};
   end

   pipe_reg #(
      .payload_t(dec_payload_t)
   ) dec_reg (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_valid (instr_valid && !hazard),
      .in_ready (pipe_ready),
      .in_data  (payload),
      .out_valid(d_valid),
      .out_ready(d_ready),
      .out_data (d_data)
   );

   // register is free when idle or retiring on this edge
   assign dst_free = !busy_q[instr.dst] || (retire0 && retire0_idx == instr.dst)
                   || (retire1 && retire1_idx == instr.dst);
   assign src_free = !busy_q[instr.src] || (retire0 && retire0_idx == instr.src)
                   || (retire1 && retire1_idx == instr.src);

   a_no_busy_accept: assert property (
      @(posedge clk) disable iff (!arst_n)
      accept && instr.op inside {op_add, op_sub, op_and, op_or, op_xor,
                                 op_movi, op_addi, op_store, op_xchg}
      |-> dst_free && (src_free || instr.op inside {op_movi, op_addi})
   );

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`default_nettype none

module execute_stage
   import core_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         d_valid,
   output logic         d_ready,
   input  dec_payload_t d_data,
   output logic         e_valid,
   input  logic         e_ready,
   output exe_payload_t e_data
);

   exe_payload_t result;

   always_comb begin
      result.op   = d_data.op;
      result.dst  = d_data.dst;
      result.src  = d_data.src;
      result.size = d_data.size;
      result.hi   = '0;
      // store address is base register plus immediate
      result.addr = d_data.src_val + d_data.imm;
      case (d_data.op)
         op_add:   result.lo = d_data.dst_val + d_data.src_val;
         op_sub:   result.lo = d_data.dst_val - d_data.src_val;
         op_and:   result.lo = d_data.dst_val & d_data.src_val;
         op_or:    result.lo = d_data.dst_val | d_data.src_val;
         op_xor:   result.lo = d_data.dst_val ^ d_data.src_val;
         op_movi:  result.lo = d_data.imm;
         op_addi:  result.lo = d_data.dst_val + d_data.imm;
         op_store: result.lo = d_data.dst_val;
         op_xchg: begin
            // lo goes to dst, hi goes to src
            result.lo = d_data.src_val;
            result.hi = d_data.dst_val;
         end
         default:  result.lo = '0;
      endcase
   end

   pipe_reg #(
      .payload_t(exe_payload_t)
   ) exe_reg (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_valid (d_valid),
      .in_ready (d_ready),
      .in_data  (result),
      .out_valid(e_valid),
      .out_ready(e_ready),
      .out_data (e_data)
   );

endmodule

`default_nettype wire

// File: verilog/pipe_reg.sv
`default_nettype none

module pipe_reg
   import core_pkg::*;
#(
   parameter type payload_t = word_t
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     full_q;
   payload_t data_q;

   // free slot, or the entry leaves on this edge
   assign in_ready = !full_q || out_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         full_q <= 1'b0;
      end else if (in_valid && in_ready) begin
         full_q <= 1'b1;
      end else if (out_ready) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         data_q <= in_data;
      end
   end

   assign out_valid = full_q;
   assign out_data  = data_q;

   a_hold_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data)
   );

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none

module reg_file
   import core_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  reg_idx_t rd0_idx,
   input  reg_idx_t rd1_idx,
   output word_t    rd0_data,
   output word_t    rd1_data,
   input  logic     wr0_en,
   input  logic     wr1_en,
   input  reg_idx_t wr0_idx,
   input  reg_idx_t wr1_idx,
   input  word_t    wr0_data,
   input  word_t    wr1_data
);

   word_t regs [reg_count];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wr0_en) begin
            regs[wr0_idx] <= wr0_data;
         end
         if (wr1_en) begin
            regs[wr1_idx] <= wr1_data;
         end
      end
   end

   // bypass a write landing this cycle so decode gets the new value
   function automatic word_t read_port(input reg_idx_t idx);
      word_t value;
      value = regs[idx];
      if (wr1_en && wr1_idx == idx) begin
         value = wr1_data;
      end
      if (wr0_en && wr0_idx == idx) begin
         value = wr0_data;
      end
      return value;
   endfunction

   always_comb rd0_data = read_port(rd0_idx);
   always_comb rd1_data = read_port(rd1_idx);

   // xchg with src == dst must only use port 0
   a_no_dual_write: assert property (
      @(posedge clk) disable iff (!arst_n)
      wr0_en && wr1_en |-> wr0_idx != wr1_idx
   );

endmodule

`default_nettype wire

// File: verilog/result_stage.sv
`default_nettype none

module result_stage
   import core_pkg::*;
(
   input  logic               e_valid,
   output logic               e_ready,
   input  exe_payload_t       e_data,
   output logic               wr0_en,
   output logic               wr1_en,
   output reg_idx_t           wr0_idx,
   output reg_idx_t           wr1_idx,
   output word_t              wr0_data,
   output word_t              wr1_data,
   output logic               wmem_valid,
   input  logic               wmem_ready,
   output word_t              wmem_address,
   output word_t              wmem_wr_data,
   output logic [wsize_w-1:0] wmem_wr_size
);

   logic is_store;
   logic writes_dst;

   assign is_store = e_data.op == op_store;

   always_comb begin
      case (e_data.op)
         op_add, op_sub, op_and, op_or, op_xor,
         op_movi, op_addi, op_xchg: writes_dst = 1'b1;
         default:                   writes_dst = 1'b0;
      endcase
   end

   // register ops retire at once, stores wait for the memory port
   assign e_ready = !(e_valid && is_store) || wmem_ready;

   assign wr0_en   = e_valid && writes_dst;
   assign wr0_idx  = e_data.dst;
   assign wr0_data = e_data.lo;

   // second write only when xchg names two different registers
   assign wr1_en   = e_valid && e_data.op == op_xchg && e_data.src != e_data.dst;
   assign wr1_idx  = e_data.src;
   assign wr1_data = e_data.hi;

   assign wmem_valid   = e_valid && is_store;
   assign wmem_address = e_data.addr;

   // size code is log2 of the byte count
   always_comb begin
      case (e_data.size)
         sz_byte: begin
            wmem_wr_size = wsize_w'(0);
            wmem_wr_data = {{(data_w-8){1'b0}}, e_data.lo[7:0]};
         end
         sz_half: begin
            wmem_wr_size = wsize_w'(1);
            wmem_wr_data = {{(data_w-16){1'b0}}, e_data.lo[15:0]};
         end
         default: begin
            wmem_wr_size = wsize_w'(2);
            wmem_wr_data = e_data.lo;
         end
      endcase
   end

   always_comb begin
      a_wmem_is_store: assert final (!wmem_valid || (e_valid && e_data.op == op_store));
   end

endmodule

`default_nettype wire
